/* source/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int words_per_line = 16;
    localparam int num_ways       = 2;
    localparam int num_sets       = 128;
    localparam int bytes_per_word = 4;

    localparam int offset_bits = 4;
    localparam int index_bits  = 7;
    localparam int tag_bits    = 19;

    typedef logic [8*bytes_per_word-1:0] word_t;
    typedef logic [bytes_per_word-1:0]   strobe_t;
    typedef logic [tag_bits-1:0]         tag_t;
    typedef logic [index_bits-1:0]       index_t;
    typedef logic [offset_bits-1:0]      offset_t;
    typedef logic                        way_t;

    // byte address as seen by the cache
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic [1:0] align;
    } addr_t;

    // word address into the data array
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } ram_addr_t;

endpackage

`default_nettype wire

/* source/dcache_ifs.sv */
`default_nettype none

// one port of the data array
interface ram_port_if;
    import dcache_pkg::*;

    logic      en;
    strobe_t   strobe;
    ram_addr_t addr;
    word_t     wdata;
    word_t     rdata;

    modport user (output en, strobe, addr, wdata, input rdata);
    modport ram  (input en, strobe, addr, wdata, output rdata);
endinterface

// miss hand-off, lookup to refill sequencer
interface miss_if;
    import dcache_pkg::*;

    logic   miss_valid;
    logic   miss_ready;
    index_t index;
    tag_t   tag;
    way_t   victim_way;
    tag_t   victim_tag;
    logic   victim_dirty;

    modport lookup (
        output miss_valid, index, tag, victim_way, victim_tag, victim_dirty,
        input  miss_ready
    );
    modport engine (
        input  miss_valid, index, tag, victim_way, victim_tag, victim_dirty,
        output miss_ready
    );
endinterface

// line commands, writeback beats and fill beats
interface line_bus_if;
    import dcache_pkg::*;

    logic  cmd_valid;
    logic  cmd_ready;
    logic  cmd_write;
    addr_t cmd_line;
    logic  wb_valid;
    word_t wb_data;
    logic  wb_done;
    logic  fill_valid;
    word_t fill_data;
    logic  fill_last;

    modport engine (
        output cmd_valid, cmd_write, cmd_line, wb_valid, wb_data,
        input  cmd_ready, wb_done, fill_valid, fill_data, fill_last
    );
    modport port (
        input  cmd_valid, cmd_write, cmd_line, wb_valid, wb_data,
        output cmd_ready, wb_done, fill_valid, fill_data, fill_last
    );
endinterface

`default_nettype wire

/* source/data_array.sv */
`default_nettype none

module data_array (
    input logic     clk,
    ram_port_if.ram a,
    ram_port_if.ram b
);
    import dcache_pkg::*;

    word_t mem [num_ways*num_sets*words_per_line];

    always_ff @(posedge clk) begin
        for (int i = 0; i < bytes_per_word; i++) begin
            if (a.en && a.strobe[i]) begin
                mem[a.addr][8*i +: 8] <= a.wdata[8*i +: 8];
            end
            if (b.en && b.strobe[i]) begin
                mem[b.addr][8*i +: 8] <= b.wdata[8*i +: 8];
            end
        end
        // read word held until the next read on that port
        if (a.en && a.strobe == '0) begin
            a.rdata <= mem[a.addr];
        end
        if (b.en && b.strobe == '0) begin
            b.rdata <= mem[b.addr];
        end
    end

    // hit port and refill port never write the same word together
    assert property (@(posedge clk)
        !(a.en && b.en && a.strobe != '0 && b.strobe != '0 && a.addr == b.addr));

endmodule

`default_nettype wire

/* source/tag_lookup.sv */
`default_nettype none

module tag_lookup (
    input  logic                clk,
    input  logic                resetn,
    input  logic                req_valid,
    output logic                req_ready,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::word_t   req_wdata,
    input  dcache_pkg::strobe_t req_strobe,
    output logic                resp_valid,
    input  logic                resp_ready,
    output dcache_pkg::word_t   resp_data,
    ram_port_if.user            ram,
    miss_if.lookup              miss
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_DATA, S_RESP, S_MISS} state_t;

    state_t state;

    addr_t   req_addr_q;
    word_t   req_wdata_q;
    strobe_t req_strobe_q;

    tag_t tag_q [num_ways][num_sets];
    logic [num_ways-1:0][num_sets-1:0] valid_q;
    logic [num_ways-1:0][num_sets-1:0] dirty_q;
    // way to evict next in each set
    logic [num_sets-1:0] lru_q;

    index_t idx;
    logic   hit;
    way_t   hit_way;
    way_t   victim;
    logic   accept;
    logic   refill_done;

    assign idx         = req_addr_q.index;
    assign victim      = lru_q[idx];
    assign req_ready   = (state == S_IDLE);
    assign accept      = req_valid && req_ready;
    assign refill_done = (state == S_MISS) && miss.miss_ready;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid_q[w][idx] && tag_q[w][idx] == req_addr_q.tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // port A only touched in the lookup cycle of a hit
    assign ram.en     = (state == S_LOOKUP) && hit;
    assign ram.strobe = req_strobe_q;
    assign ram.addr   = '{way: hit_way, index: idx, offset: req_addr_q.offset};
    assign ram.wdata  = req_wdata_q;

    assign miss.index        = idx;
    assign miss.tag          = req_addr_q.tag;
    assign miss.victim_way   = victim;
    assign miss.victim_tag   = tag_q[victim][idx];
    assign miss.victim_dirty = valid_q[victim][idx] && dirty_q[victim][idx];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state           <= S_IDLE;
            resp_valid      <= 1'b0;
            miss.miss_valid <= 1'b0;
            valid_q         <= '0;
            dirty_q         <= '0;
            lru_q           <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        lru_q[idx] <= ~hit_way;
                        if (req_strobe_q != '0) begin
                            dirty_q[hit_way][idx] <= 1'b1;
                        end
                        state <= S_DATA;
                    end else begin
                        miss.miss_valid <= 1'b1;
                        state           <= S_MISS;
                    end
                end
                S_DATA: begin
                    resp_valid <= 1'b1;
                    state      <= S_RESP;
                end
                S_RESP: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                S_MISS: begin
                    // line is in the array now, replay as a hit
                    if (refill_done) begin
                        valid_q[victim][idx] <= 1'b1;
                        dirty_q[victim][idx] <= 1'b0;
                        lru_q[idx]           <= ~victim;
                        miss.miss_valid      <= 1'b0;
                        state                <= S_LOOKUP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q   <= req_addr;
            req_wdata_q  <= req_wdata;
            req_strobe_q <= req_strobe;
        end
        if (refill_done) begin
            tag_q[victim][idx] <= req_addr_q.tag;
        end
        if (state == S_DATA) begin
            resp_data <= ram.rdata;
        end
    end

    assert property (@(posedge clk) disable iff (resetn) !(resp_valid && miss.miss_valid));

    assert property (@(posedge clk) disable iff (resetn)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

endmodule

`default_nettype wire

/* source/miss_engine.sv */
`default_nettype none

module miss_engine (
    input logic        clk,
    input logic        resetn,
    miss_if.engine     miss,
    ram_port_if.user   ram,
    line_bus_if.engine bus
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_VICTIM, S_WB_CMD, S_FETCH_CMD, S_REFILL, S_DONE
    } state_t;

    state_t  state;
    offset_t offset_q;
    logic    rd_pending_q;
    logic    wb_sent_q;

    // victim words leave port B one cycle after their read
    assign bus.wb_valid = rd_pending_q;
    assign bus.wb_data  = ram.rdata;

    // write command waits for the last victim word
    assign bus.cmd_valid = (state == S_WB_CMD && !rd_pending_q && !wb_sent_q)
                        || state == S_FETCH_CMD;
    assign bus.cmd_write = (state == S_WB_CMD);
    assign bus.cmd_line  = '{
        tag:    (state == S_WB_CMD) ? miss.victim_tag : miss.tag,
        index:  miss.index,
        offset: '0,
        align:  '0
    };

    assign ram.en     = (state == S_VICTIM) || (state == S_REFILL && bus.fill_valid);
    assign ram.strobe = {bytes_per_word{state == S_REFILL}};
    assign ram.addr   = '{way: miss.victim_way, index: miss.index, offset: offset_q};
    assign ram.wdata  = bus.fill_data;

    assign miss.miss_ready = (state == S_DONE);

    always_ff @(posedge clk) begin
        if (resetn) begin
            state        <= S_IDLE;
            offset_q     <= '0;
            rd_pending_q <= 1'b0;
            wb_sent_q    <= 1'b0;
        end else begin
            rd_pending_q <= (state == S_VICTIM);
            case (state)
                S_IDLE: begin
                    offset_q <= '0;
                    if (miss.miss_valid) begin
                        state <= miss.victim_dirty ? S_VICTIM : S_FETCH_CMD;
                    end
                end
                S_VICTIM: begin
                    offset_q <= offset_q + 1'b1;
                    if (offset_q == offset_t'(words_per_line - 1)) begin
                        state <= S_WB_CMD;
                    end
                end
                S_WB_CMD: begin
                    if (bus.cmd_valid && bus.cmd_ready) begin
                        wb_sent_q <= 1'b1;
                    end
                    if (bus.wb_done) begin
                        wb_sent_q <= 1'b0;
                        state     <= S_FETCH_CMD;
                    end
                end
                S_FETCH_CMD: begin
                    if (bus.cmd_ready) begin
                        state <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (bus.fill_valid) begin
                        offset_q <= offset_q + 1'b1;
                        if (bus.fill_last) begin
                            state <= S_DONE;
                        end
                    end
                end
                S_DONE: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // memory only returns data for a fetch issued from here
    assert property (@(posedge clk) disable iff (resetn)
        bus.fill_valid |-> state == S_REFILL);

endmodule

`default_nettype wire

/* source/mem_burst_port.sv */
`default_nettype none

module mem_burst_port (
    input  logic              clk,
    input  logic              resetn,
    line_bus_if.port          bus,
    output logic              mem_req_valid,
    output logic              mem_req_write,
    output dcache_pkg::addr_t mem_req_addr,
    output dcache_pkg::word_t mem_req_wdata,
    output logic              mem_req_last,
    input  logic              mem_req_ready,
    input  logic              mem_rvalid,
    input  dcache_pkg::word_t mem_rdata,
    input  logic              mem_rlast
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_WRITE, S_READ_REQ, S_READ_DATA} state_t;

    state_t  state;
    addr_t   line_q;
    offset_t beat_q;
    offset_t fill_ptr_q;
    // victim line buffer
    word_t   line_buf [words_per_line];

    assign bus.cmd_ready  = (state == S_IDLE);
    assign bus.fill_valid = mem_rvalid;
    assign bus.fill_data  = mem_rdata;
    assign bus.fill_last  = mem_rlast;

    assign mem_req_valid = (state == S_WRITE) || (state == S_READ_REQ);
    assign mem_req_write = (state == S_WRITE);
    assign mem_req_wdata = line_buf[beat_q];
    assign mem_req_last  = (state == S_WRITE) && beat_q == offset_t'(words_per_line - 1);

    // write beats step the word address, the fetch uses the line base
    always_comb begin
        mem_req_addr        = line_q;
        mem_req_addr.offset = beat_q;
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state       <= S_IDLE;
            beat_q      <= '0;
            fill_ptr_q  <= '0;
            bus.wb_done <= 1'b0;
        end else begin
            bus.wb_done <= 1'b0;
            if (bus.wb_valid) begin
                fill_ptr_q <= fill_ptr_q + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (bus.cmd_valid) begin
                        beat_q <= '0;
                        state  <= bus.cmd_write ? S_WRITE : S_READ_REQ;
                    end
                end
                S_WRITE: begin
                    if (mem_req_ready) begin
                        beat_q <= beat_q + 1'b1;
                        if (mem_req_last) begin
                            bus.wb_done <= 1'b1;
                            state       <= S_IDLE;
                        end
                    end
                end
                S_READ_REQ: begin
                    if (mem_req_ready) begin
                        state <= S_READ_DATA;
                    end
                end
                S_READ_DATA: begin
                    if (mem_rvalid && mem_rlast) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (bus.wb_valid) begin
            line_buf[fill_ptr_q] <= bus.wb_data;
        end
        if (state == S_IDLE && bus.cmd_valid) begin
            line_q <= bus.cmd_line;
        end
    end

endmodule

`default_nettype wire

/* source/dcache_top.sv */
`default_nettype none

module dcache_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                req_valid,
    output logic                req_ready,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::word_t   req_wdata,
    input  dcache_pkg::strobe_t req_strobe,
    output logic                resp_valid,
    input  logic                resp_ready,
    output dcache_pkg::word_t   resp_data,
    output logic                mem_req_valid,
    output logic                mem_req_write,
    output dcache_pkg::addr_t   mem_req_addr,
    output dcache_pkg::word_t   mem_req_wdata,
    output logic                mem_req_last,
    input  logic                mem_req_ready,
    input  logic                mem_rvalid,
    input  dcache_pkg::word_t   mem_rdata,
    input  logic                mem_rlast
);
    ram_port_if port_a ();
    ram_port_if port_b ();
    miss_if     miss_bus ();
    line_bus_if line_bus ();

    tag_lookup i_tag_lookup (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_strobe (req_strobe),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data),
        .ram        (port_a),
        .miss       (miss_bus)
    );

    miss_engine i_miss_engine (
        .clk    (clk),
        .resetn (resetn),
        .miss   (miss_bus),
        .ram    (port_b),
        .bus    (line_bus)
    );

    mem_burst_port i_mem_burst_port (
        .clk           (clk),
        .resetn        (resetn),
        .bus           (line_bus),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_last  (mem_req_last),
        .mem_req_ready (mem_req_ready),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata),
        .mem_rlast     (mem_rlast)
    );

    data_array i_data_array (
        .clk (clk),
        .a   (port_a),
        .b   (port_b)
    );

endmodule

`default_nettype wire

/* tests/mem_model.sv */
`default_nettype none

module mem_model (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req_valid,
    input  logic        req_write,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    input  logic        req_last,
    output logic        req_ready,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic        rlast,
    output int          req_beats,
    output int          write_bursts,
    output int          errors
);
    // sparse 64K-word store
    logic [31:0] mem [logic [15:0]];

    int          burst_beats;
    int          fill_left;
    int          fill_wait;
    logic [15:0] next_wr;
    logic [15:0] fill_addr;

    // untouched words read back as their own byte address
    function automatic logic [31:0] read_word(input logic [15:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {14'b0, a, 2'b00};
    endfunction

    task automatic take_write_beat();
        if (burst_beats != 0 && req_addr[17:2] != next_wr) begin
            $display("memory write beat at 0x%08h is out of sequence", req_addr);
            errors++;
        end
        mem[req_addr[17:2]] = req_wdata;
        next_wr = req_addr[17:2] + 16'd1;
        burst_beats++;
        if (req_last) begin
            if (burst_beats != 16) begin
                $display("memory write burst had %0d beats instead of 16", burst_beats);
                errors++;
            end
            write_bursts++;
            burst_beats = 0;
        end else if (burst_beats == 16) begin
            $display("memory write burst went past 16 beats without a last beat");
            errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h18d1_4d37));
        req_ready    = 1'b0;
        rvalid       = 1'b0;
        rdata        = '0;
        rlast        = 1'b0;
        req_beats    = 0;
        write_bursts = 0;
        errors       = 0;
        burst_beats  = 0;
        fill_left    = 0;
        fill_wait    = 0;
        next_wr      = '0;
        fill_addr    = '0;
    end

    always @(posedge clk) begin
        #1;
        rvalid = 1'b0;
        rlast  = 1'b0;
        if (resetn) begin
            req_ready   = 1'b0;
            fill_left   = 0;
            burst_beats = 0;
        end else begin
            // fill beats with random gaps
            if (fill_left > 0) begin
                if (fill_wait > 0) begin
                    fill_wait--;
                end else begin
                    rvalid    = 1'b1;
                    rdata     = read_word(fill_addr);
                    rlast     = (fill_left == 1);
                    fill_addr = fill_addr + 16'd1;
                    fill_left--;
                    fill_wait = $urandom % 3;
                end
            end
            req_ready = ($urandom % 4) != 0;
            // beat shown now is taken at the coming edge
            if (req_valid && req_ready) begin
                req_beats++;
                if (req_write) begin
                    take_write_beat();
                end else begin
                    if (req_addr[5:0] != 6'd0) begin
                        $display("memory fetch at 0x%08h is not line aligned", req_addr);
                        errors++;
                    end
                    fill_addr = req_addr[17:2];
                    fill_left = 16;
                    fill_wait = 1 + $urandom % 4;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tests/dcache_tb.sv */
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int wait_limit = 1000;

    logic    clk;
    logic    resetn;
    logic    req_valid;
    logic    req_ready;
    addr_t   req_addr;
    word_t   req_wdata;
    strobe_t req_strobe;
    logic    resp_valid;
    logic    resp_ready;
    word_t   resp_data;
    logic    mem_req_valid;
    logic    mem_req_write;
    addr_t   mem_req_addr;
    word_t   mem_req_wdata;
    logic    mem_req_last;
    logic    mem_req_ready;
    logic    mem_rvalid;
    word_t   mem_rdata;
    logic    mem_rlast;

    int   mem_req_beats;
    int   mem_write_bursts;
    int   mem_errors;
    int   checks;
    int   errors;
    logic timed_out;

    dcache_top i_dut (
        .clk           (clk),
        .resetn        (resetn),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_strobe    (req_strobe),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_data     (resp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_last  (mem_req_last),
        .mem_req_ready (mem_req_ready),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata),
        .mem_rlast     (mem_rlast)
    );

    mem_model i_mem (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (mem_req_valid),
        .req_write    (mem_req_write),
        .req_addr     (mem_req_addr),
        .req_wdata    (mem_req_wdata),
        .req_last     (mem_req_last),
        .req_ready    (mem_req_ready),
        .rvalid       (mem_rvalid),
        .rdata        (mem_rdata),
        .rlast        (mem_rlast),
        .req_beats    (mem_req_beats),
        .write_bursts (mem_write_bursts),
        .errors       (mem_errors)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // one trace line: offer, wait for acceptance, wait for the response
    task automatic run_request(input byte op, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strobe,
                               input logic [31:0] expected);
        int          waited;
        int          latency;
        int          beats_before;
        logic        took;
        logic [31:0] held;
        req_valid  = 1'b1;
        req_addr   = addr;
        req_wdata  = wdata;
        req_strobe = strobe;
        waited = 0;
        while (!req_ready && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!req_ready) begin
            $display("timeout: request to 0x%08h was never accepted", addr);
            errors++;
            timed_out  = 1'b1;
            req_valid  = 1'b0;
            return;
        end
        beats_before = mem_req_beats;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        latency = 0;
        while (!resp_valid && latency < wait_limit) begin
            @(posedge clk);
            #1;
            latency++;
        end
        if (!resp_valid) begin
            $display("timeout: no response for request to 0x%08h", addr);
            errors++;
            timed_out = 1'b1;
            return;
        end
        held = resp_data;
        // response side stalls at random
        took = 1'b0;
        waited = 0;
        while (!took && waited < wait_limit) begin
            resp_ready = ($urandom % 3) != 0;
            took = resp_ready;
            @(posedge clk);
            #1;
            waited++;
            if (!took) begin
                check_value("resp_valid", 32'(resp_valid), 1);
                check_value("resp_data", resp_data, held);
            end
        end
        resp_ready = 1'b0;
        if (op != "w") begin
            check_value("resp_data", held, expected);
        end
        if (op == "h") begin
            check_value("resp_valid latency", latency, 2);
            check_value("mem_req beats on hit", mem_req_beats - beats_before, 0);
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        int          requests;
        string       line;
        byte         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic [3:0]  strobe;
        clk        = 1'b0;
        resetn     = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_strobe = '0;
        resp_ready = 1'b0;
        checks     = 0;
        errors     = 0;
        timed_out  = 1'b0;
        requests   = 0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b0;
        check_value("resp_valid", 32'(resp_valid), 0);
        check_value("mem_req_valid", 32'(mem_req_valid), 0);
        check_value("req_ready", 32'(req_ready), 1);

        fd = $fopen("tests/dcache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the request trace");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, strobe, expected);
                    if (fields == 5) begin
                        run_request(op, addr, wdata, strobe, expected);
                        requests++;
                    end
                end
            end
            $fclose(fd);
        end

        if (requests == 0) begin
            $display("no requests were read from the trace");
            errors++;
        end
        if (mem_write_bursts == 0) begin
            $display("no dirty line was written back to memory");
            errors++;
        end
        errors += mem_errors;
        $display("checks: %0d, errors: %0d, memory write bursts: %0d",
                 checks, errors, mem_write_bursts);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/dcache_trace.txt */
# op address wdata strobe expected
# op: r read, h read that must hit, w write with expected unused
# set 65 lines 0x1040, 0x3044, 0x5048 force dirty evictions
r 00000100 00000000 0 00000100
h 00000104 00000000 0 00000104
h 0000013c 00000000 0 0000013c
w 00000108 aabbccdd 3 00000000
h 00000108 00000000 0 0000ccdd
w 00000108 11223344 c 00000000
h 00000108 00000000 0 1122ccdd
w 00001040 a0000001 f 00000000
w 00003044 b0000002 f 00000000
w 00005048 c0000003 f 00000000
r 00001040 00000000 0 a0000001
r 00003044 00000000 0 b0000002
r 00005048 00000000 0 c0000003
h 00005048 00000000 0 c0000003
h 00003044 00000000 0 b0000002
r 0000107c 00000000 0 0000107c
r 0000504c 00000000 0 0000504c
r 00020000 00000000 0 00020000
h 00020004 00000000 0 00020004
w 0002003c 5a5a5a5a 5 00000000
h 0002003c 00000000 0 005a005a
h 00000108 00000000 0 1122ccdd
r 00002100 00000000 0 00002100
r 00004104 00000000 0 00004104
r 00000108 00000000 0 1122ccdd

/* flist.f */
source/dcache_pkg.sv
source/dcache_ifs.sv
source/data_array.sv
source/tag_lookup.sv
source/miss_engine.sv
source/mem_burst_port.sv
source/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcache_tb -f flist.f
./obj_dir/Vdcache_tb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
